// File: Makefile
VERILATOR ?= verilator
TOP ?= aesDecryptTb
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Finished with no errors

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) verif/tbHandshake.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/aesDecryptTop.sv
`timescale 1ns/1ns

module aesDecryptTop (
	input logic Clk,
	input logic rst,
	input logic inReq,
	input aesPkg::word_t inWord,
	output logic inAck,
	output logic outReq,
	output aesPkg::word_t outWord,
	input logic outAck
);

	logic blockTake;
	logic blockFull;
	logic keyStart;
	logic keyReady;
	logic unloadBusy;
	logic resultValid;
	aesPkg::block_t loadKey;
	aesPkg::block_t loadBlock;
	aesPkg::block_t cipherKey;
	aesPkg::block_t roundKey;
	aesPkg::block_t plainBlock;
	aesPkg::roundIdx_t rkIndex;

	wordLoader loader (
		.Clk(Clk),
		.rst(rst),
		.inReq(inReq),
		.inWord(inWord),
		.inAck(inAck),
		.blockTake(blockTake),
		.blockFull(blockFull),
		.loadKey(loadKey),
		.loadBlock(loadBlock)
	);

	decryptCore core (
		.Clk(Clk),
		.rst(rst),
		.blockFull(blockFull),
		.loadKey(loadKey),
		.loadBlock(loadBlock),
		.blockTake(blockTake),
		.keyStart(keyStart),
		.cipherKey(cipherKey),
		.keyReady(keyReady),
		.rkIndex(rkIndex),
		.roundKey(roundKey),
		.unloadBusy(unloadBusy),
		.resultValid(resultValid),
		.plainBlock(plainBlock)
	);

	keyExpander keySchedule (
		.Clk(Clk),
		.rst(rst),
		.keyStart(keyStart),
		.cipherKey(cipherKey),
		.rkIndex(rkIndex),
		.roundKey(roundKey),
		.keyReady(keyReady)
	);

	wordUnloader unloader (
		.Clk(Clk),
		.rst(rst),
		.resultValid(resultValid),
		.plainBlock(plainBlock),
		.unloadBusy(unloadBusy),
		.outReq(outReq),
		.outWord(outWord),
		.outAck(outAck)
	);

endmodule

// File: design/aesPkg.sv
package aesPkg;

	localparam int wordWidth = 32;
	localparam int blockWidth = 128;
	localparam int numRounds = 10;
	localparam int wordsPerBlock = 4;

	typedef logic [wordWidth-1:0] word_t;
	typedef logic [blockWidth-1:0] block_t;
	typedef logic [3:0] roundIdx_t;

	// four-phase endpoint: idle, ack or req raised, waiting for release
	typedef enum logic [1:0] {
		hsIdle,
		hsAckWait,
		hsRelease
	} hsPhase_t;

	typedef enum logic [1:0] {
		coreIdle,
		coreKey,
		coreRounds,
		coreHandOff
	} coreState_t;

	// forward S-box, entry 0 in the top byte
	localparam logic [0:255][7:0] sbox = {
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	// inverse S-box, same layout
	localparam logic [0:255][7:0] invSbox = {
		128'h52096ad53036a538bf40a39e81f3d7fb,
		128'h7ce339829b2fff87348e4344c4dee9cb,
		128'h547b9432a6c2233dee4c950b42fac34e,
		128'h082ea16628d924b2765ba2496d8bd125,
		128'h72f8f66486689816d4a45ccc5d65b692,
		128'h6c704850fdedb9da5e154657a78d9d84,
		128'h90d8ab008cbcd30af7e45805b8b34506,
		128'hd02c1e8fca3f0f02c1afbd0301138a6b,
		128'h3a9111414f67dcea97f2cfcef0b4e673,
		128'h96ac7422e7ad3585e2f937e81c75df6e,
		128'h47f11a711d29c5896fb7620eaa18be1b,
		128'hfc563e4bc6d279209adbc0fe78cd5af4,
		128'h1fdda8338807c731b11210592780ec5f,
		128'h60517fa919b54a0d2de57a9f93c99cef,
		128'ha0e03b4dae2af5b0c8ebbb3c83539961,
		128'h172b047eba77d626e169146355210c7d
	};

	// round constants for key schedule steps 1 to 10
	localparam logic [0:9][7:0] rcon = {
		8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
		8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
	};

	// multiply by 2 in GF(2^8)
	function automatic logic [7:0] xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (8'h1b & {8{b[7]}});
	endfunction

endpackage

// File: design/decryptCore.sv
`timescale 1ns/1ns

module decryptCore (
	input logic Clk,
	input logic rst,
	input logic blockFull,
	input aesPkg::block_t loadKey,
	input aesPkg::block_t loadBlock,
	output logic blockTake,
	output logic keyStart,
	output aesPkg::block_t cipherKey,
	input logic keyReady,
	output aesPkg::roundIdx_t rkIndex,
	input aesPkg::block_t roundKey,
	input logic unloadBusy,
	output logic resultValid,
	output aesPkg::block_t plainBlock
);

	aesPkg::coreState_t state;
	aesPkg::block_t stateReg;
	aesPkg::block_t roundOut;
	aesPkg::roundIdx_t round;
	logic finalRound;
	logic keyDone;

	// keyReady of the previous block is still up while keyStart is high
	assign keyDone = (state == aesPkg::coreKey) && keyReady && !keyStart;
	assign rkIndex = (state == aesPkg::coreRounds) ? round : aesPkg::roundIdx_t'(aesPkg::numRounds);
	assign finalRound = (round == '0);
	assign plainBlock = stateReg;

	invRound roundUnit (
		.stateIn(stateReg),
		.roundKey(roundKey),
		.finalRound(finalRound),
		.stateOut(roundOut)
	);

	always_ff @(posedge Clk) begin
		if (rst) begin
			state <= aesPkg::coreIdle;
			blockTake <= 1'b0;
			keyStart <= 1'b0;
			resultValid <= 1'b0;
			round <= '0;
		end else begin
			blockTake <= 1'b0;
			keyStart <= 1'b0;
			resultValid <= 1'b0;
			case (state)
				aesPkg::coreIdle: begin
					if (blockTake) begin
						keyStart <= 1'b1;
						state <= aesPkg::coreKey;
					end else if (blockFull) begin
						blockTake <= 1'b1;
					end
				end
				aesPkg::coreKey: begin
					if (keyDone) begin
						round <= aesPkg::roundIdx_t'(aesPkg::numRounds - 1);
						state <= aesPkg::coreRounds;
					end
				end
				aesPkg::coreRounds: begin
					round <= round - 4'd1;
					if (finalRound) begin
						resultValid <= !unloadBusy;
						state <= unloadBusy ? aesPkg::coreHandOff : aesPkg::coreIdle;
					end
				end
				default: begin
					if (!unloadBusy) begin
						resultValid <= 1'b1;
						state <= aesPkg::coreIdle;
					end
				end
			endcase
		end
	end

	always_ff @(posedge Clk) begin
		if (state == aesPkg::coreIdle && blockTake) begin
			cipherKey <= loadKey;
			stateReg <= loadBlock;
		end else if (keyDone) begin
			stateReg <= stateReg ^ roundKey;
		end else if (state == aesPkg::coreRounds) begin
			stateReg <= roundOut;
		end
	end

	assert property (@(posedge Clk) disable iff (rst) !(resultValid && unloadBusy))
		else $error("result handed over while output stage busy");

endmodule

// File: design/invRound.sv
`timescale 1ns/1ns

module invRound (
	input aesPkg::block_t stateIn,
	input aesPkg::block_t roundKey,
	input logic finalRound,
	output aesPkg::block_t stateOut
);

	aesPkg::block_t shifted;
	aesPkg::block_t subbed;
	aesPkg::block_t keyed;
	aesPkg::block_t mixed;

	// k selects which of b, 2b, 4b, 8b are summed
	function automatic logic [7:0] gfMul(input logic [7:0] b, input logic [3:0] k);
		logic [7:0] x2;
		logic [7:0] x4;
		logic [7:0] x8;
		x2 = aesPkg::xtime(b);
		x4 = aesPkg::xtime(x2);
		x8 = aesPkg::xtime(x4);
		return ({8{k[0]}} & b) ^ ({8{k[1]}} & x2) ^ ({8{k[2]}} & x4) ^ ({8{k[3]}} & x8);
	endfunction

	function automatic aesPkg::word_t invMixCol(input aesPkg::word_t col);
		logic [7:0] b0;
		logic [7:0] b1;
		logic [7:0] b2;
		logic [7:0] b3;
		b0 = col[31:24];
		b1 = col[23:16];
		b2 = col[15:8];
		b3 = col[7:0];
		return {
			gfMul(b0, 4'he) ^ gfMul(b1, 4'hb) ^ gfMul(b2, 4'hd) ^ gfMul(b3, 4'h9),
			gfMul(b0, 4'h9) ^ gfMul(b1, 4'he) ^ gfMul(b2, 4'hb) ^ gfMul(b3, 4'hd),
			gfMul(b0, 4'hd) ^ gfMul(b1, 4'h9) ^ gfMul(b2, 4'he) ^ gfMul(b3, 4'hb),
			gfMul(b0, 4'hb) ^ gfMul(b1, 4'hd) ^ gfMul(b2, 4'h9) ^ gfMul(b3, 4'he)
		};
	endfunction

	// byte r of column c sits at bit 127 - 8*(4c + r)
	always_comb begin
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				shifted[127 - 8*(4*c + r) -: 8] = stateIn[127 - 8*(4*((c + 4 - r) % 4) + r) -: 8];
			end
		end
		for (int i = 0; i < 16; i++) begin
			subbed[8*i +: 8] = aesPkg::invSbox[shifted[8*i +: 8]];
		end
		keyed = subbed ^ roundKey;
		for (int c = 0; c < 4; c++) begin
			mixed[32*c +: 32] = invMixCol(keyed[32*c +: 32]);
		end
	end

	// last round has no mix step
	assign stateOut = finalRound ? keyed : mixed;

endmodule

// File: design/keyExpander.sv
`timescale 1ns/1ns

module keyExpander (
	input logic Clk,
	input logic rst,
	input logic keyStart,
	input aesPkg::block_t cipherKey,
	input aesPkg::roundIdx_t rkIndex,
	output aesPkg::block_t roundKey,
	output logic keyReady
);

	aesPkg::block_t roundKeys [0:aesPkg::numRounds];
	aesPkg::block_t srcKey;
	aesPkg::block_t nextKey;
	aesPkg::word_t rotSub;
	aesPkg::roundIdx_t rcnt;
	logic [7:0] rconByte;
	logic busy;

	function automatic aesPkg::word_t subWord(input aesPkg::word_t w);
		return {aesPkg::sbox[w[31:24]], aesPkg::sbox[w[23:16]],
			aesPkg::sbox[w[15:8]], aesPkg::sbox[w[7:0]]};
	endfunction

	// key 1 is derived straight from the input so key 10 lands 10 cycles on
	always_comb begin
		srcKey = roundKeys[rcnt];
		rconByte = aesPkg::rcon[0];
		if (keyStart) begin
			srcKey = cipherKey;
		end else if (rcnt < aesPkg::numRounds) begin
			rconByte = aesPkg::rcon[rcnt];
		end
		rotSub = subWord({srcKey[23:0], srcKey[31:24]}) ^ {rconByte, 24'h0};
		nextKey[127:96] = srcKey[127:96] ^ rotSub;
		nextKey[95:64] = srcKey[95:64] ^ nextKey[127:96];
		nextKey[63:32] = srcKey[63:32] ^ nextKey[95:64];
		nextKey[31:0] = srcKey[31:0] ^ nextKey[63:32];
	end

	always_ff @(posedge Clk) begin
		if (rst) begin
			rcnt <= '0;
			busy <= 1'b0;
			keyReady <= 1'b0;
		end else if (keyStart) begin
			rcnt <= 4'd1;
			busy <= 1'b1;
			keyReady <= 1'b0;
		end else if (busy) begin
			rcnt <= rcnt + 4'd1;
			if (rcnt == aesPkg::roundIdx_t'(aesPkg::numRounds - 1)) begin
				busy <= 1'b0;
				keyReady <= 1'b1;
			end
		end
	end

	always_ff @(posedge Clk) begin
		if (keyStart) begin
			roundKeys[0] <= cipherKey;
			roundKeys[1] <= nextKey;
		end else if (busy) begin
			roundKeys[rcnt + 4'd1] <= nextKey;
		end
	end

	// read in any order once ready
	assign roundKey = roundKeys[rkIndex];

	assert property (@(posedge Clk) disable iff (rst) rcnt <= aesPkg::numRounds)
		else $error("key schedule counter past last round");

endmodule

// File: design/wordLoader.sv
`timescale 1ns/1ns

module wordLoader (
	input logic Clk,
	input logic rst,
	input logic inReq,
	input aesPkg::word_t inWord,
	output logic inAck,
	input logic blockTake,
	output logic blockFull,
	output aesPkg::block_t loadKey,
	output aesPkg::block_t loadBlock
);

	aesPkg::hsPhase_t phase;
	logic [2:0] wordCnt;
	logic take;

	// no new word while a full block waits for the core
	assign take = (phase == aesPkg::hsIdle) && inReq && !blockFull;

	always_ff @(posedge Clk) begin
		if (rst) begin
			phase <= aesPkg::hsIdle;
			inAck <= 1'b0;
			wordCnt <= '0;
			blockFull <= 1'b0;
		end else begin
			if (blockTake) begin
				blockFull <= 1'b0;
			end
			case (phase)
				aesPkg::hsIdle: begin
					if (take) begin
						inAck <= 1'b1;
						wordCnt <= wordCnt + 3'd1;
						if (wordCnt == 3'd7) begin
							blockFull <= 1'b1;
						end
						phase <= aesPkg::hsAckWait;
					end
				end
				aesPkg::hsAckWait: begin
					if (!inReq) begin
						inAck <= 1'b0;
						phase <= aesPkg::hsRelease;
					end
				end
				default: phase <= aesPkg::hsIdle;
			endcase
		end
	end

	// words 0-3 are key, 4-7 ciphertext, msw first
	always_ff @(posedge Clk) begin
		if (take) begin
			if (wordCnt < aesPkg::wordsPerBlock) begin
				loadKey <= {loadKey[aesPkg::blockWidth-aesPkg::wordWidth-1:0], inWord};
			end else begin
				loadBlock <= {loadBlock[aesPkg::blockWidth-aesPkg::wordWidth-1:0], inWord};
			end
		end
	end

	assert property (@(posedge Clk) disable iff (rst) $rose(inAck) |-> $past(inReq))
		else $error("inAck rose without a pending inReq");

endmodule

// File: design/wordUnloader.sv
`timescale 1ns/1ns

module wordUnloader (
	input logic Clk,
	input logic rst,
	input logic resultValid,
	input aesPkg::block_t plainBlock,
	output logic unloadBusy,
	output logic outReq,
	output aesPkg::word_t outWord,
	input logic outAck
);

	aesPkg::hsPhase_t phase;
	aesPkg::block_t outBlk;
	logic [1:0] wordCnt;
	logic wordDone;

	assign wordDone = (phase == aesPkg::hsRelease) && !outAck;
	assign outWord = outBlk[aesPkg::blockWidth-1 -: aesPkg::wordWidth];

	always_ff @(posedge Clk) begin
		if (rst) begin
			phase <= aesPkg::hsIdle;
			outReq <= 1'b0;
			unloadBusy <= 1'b0;
			wordCnt <= '0;
		end else if (resultValid) begin
			unloadBusy <= 1'b1;
			wordCnt <= '0;
		end else begin
			case (phase)
				aesPkg::hsIdle: begin
					if (unloadBusy) begin
						outReq <= 1'b1;
						phase <= aesPkg::hsAckWait;
					end
				end
				aesPkg::hsAckWait: begin
					if (outAck) begin
						outReq <= 1'b0;
						phase <= aesPkg::hsRelease;
					end
				end
				default: begin
					// busy stays up until the last ack is gone
					if (wordDone) begin
						if (wordCnt == 2'(aesPkg::wordsPerBlock - 1)) begin
							unloadBusy <= 1'b0;
						end
						wordCnt <= wordCnt + 2'd1;
						phase <= aesPkg::hsIdle;
					end
				end
			endcase
		end
	end

	always_ff @(posedge Clk) begin
		if (resultValid) begin
			outBlk <= plainBlock;
		end else if (wordDone) begin
			outBlk <= outBlk << aesPkg::wordWidth;
		end
	end

	assert property (@(posedge Clk) disable iff (rst) outReq |=> !outReq || $stable(outWord))
		else $error("outWord changed during a request");

endmodule

// File: filelist.f
+incdir+verif
design/aesPkg.sv
design/wordLoader.sv
design/keyExpander.sv
design/invRound.sv
design/decryptCore.sv
design/wordUnloader.sv
design/aesDecryptTop.sv
verif/aesDecryptTb.sv

// File: verif/tbHandshake.svh
// wait 0 to maxCycles falling edges
task automatic waitRandom(input int maxCycles);
	int n;
	n = $urandom_range(maxCycles, 0);
	repeat (n) @(negedge Clk);
endtask

// one four-phase word, req held holdExtra cycles past the ack
task automatic sendWord(input aesPkg::word_t w, input int holdExtra);
	waitRandom(5);
	inWord = w;
	inReq = 1'b1;
	while (!inAck) @(negedge Clk);
	repeat (holdExtra) begin
		@(negedge Clk);
		assert (inAck) else begin
			$display("inAck dropped at %0t ns while inReq was still high", $time);
			errCount++;
		end
	end
	inReq = 1'b0;
	while (inAck) @(negedge Clk);
endtask

// key words first, then ciphertext, msw first
task automatic sendBlock(input aesPkg::block_t key, input aesPkg::block_t ct, input int holdExtra);
	for (int i = 0; i < aesPkg::wordsPerBlock; i++) begin
		sendWord(key[127 - 32*i -: 32], holdExtra);
	end
	for (int i = 0; i < aesPkg::wordsPerBlock; i++) begin
		sendWord(ct[127 - 32*i -: 32], holdExtra);
	end
endtask

// four output words against the expected plaintext
task automatic receiveBlock(input aesPkg::block_t expBlock, input int maxDelay);
	aesPkg::word_t expWord;
	for (int i = 0; i < aesPkg::wordsPerBlock; i++) begin
		expWord = expBlock[127 - 32*i -: 32];
		while (!outReq) @(negedge Clk);
		waitRandom(maxDelay);
		assert (outWord === expWord) else begin
			$display("[FAIL] %0t ns outWord expected %h got %h", $time, expWord, outWord);
			errCount++;
		end
		outAck = 1'b1;
		while (outReq) @(negedge Clk);
		waitRandom(maxDelay);
		outAck = 1'b0;
	end
endtask

// File: verif/aesDecryptTb.sv
`timescale 1ns/1ns

module aesDecryptTb;

	localparam int numTests = 6;
	localparam int cyclesPerTest = 200;

	// standard known-answer vectors
	localparam aesPkg::block_t key1 = 128'h000102030405060708090a0b0c0d0e0f;
	localparam aesPkg::block_t ct1 = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
	localparam aesPkg::block_t pt1 = 128'h00112233445566778899aabbccddeeff;
	localparam aesPkg::block_t key2 = 128'h2b7e151628aed2a6abf7158809cf4f3c;
	localparam aesPkg::block_t ct2 = 128'h3925841d02dc09fbdc118597196a0b32;
	localparam aesPkg::block_t pt2 = 128'h3243f6a8885a308d313198a2e0370734;

	logic Clk = 1'b0;
	logic rst;
	logic inReq;
	aesPkg::word_t inWord;
	logic inAck;
	logic outReq;
	aesPkg::word_t outWord;
	logic outAck;
	int errCount = 0;
	int errMark = 0;
	int testsFailed = 0;

	aesDecryptTop UUT (
		.Clk(Clk),
		.rst(rst),
		.inReq(inReq),
		.inWord(inWord),
		.inAck(inAck),
		.outReq(outReq),
		.outWord(outWord),
		.outAck(outAck)
	);

	always #50 Clk = ~Clk;

	`include "tbHandshake.svh"

	task automatic applyReset;
		@(negedge Clk);
		rst = 1'b1;
		inReq = 1'b0;
		outAck = 1'b0;
		repeat (2) @(negedge Clk);
		rst = 1'b0;
	endtask

	task automatic endTest(input int num, input string name);
		if (errCount == errMark) begin
			$display("test %0d %s: passed", num, name);
		end else begin
			$display("test %0d %s: %0d check(s) failed", num, name, errCount - errMark);
			testsFailed++;
		end
		errMark = errCount;
	endtask

	// four-phase rules on both streams
	assert property (@(posedge Clk) disable iff (rst) $rose(inAck) |-> $past(inReq))
		else begin
			$display("inAck rose at %0t ns without a request", $time);
			errCount++;
		end
	assert property (@(posedge Clk) disable iff (rst) $fell(inAck) |-> !$past(inReq))
		else begin
			$display("inAck fell at %0t ns before inReq was released", $time);
			errCount++;
		end
	assert property (@(posedge Clk) disable iff (rst) outReq && $past(outReq) |-> $stable(outWord))
		else begin
			$display("outWord changed at %0t ns while outReq was high", $time);
			errCount++;
		end
	assert property (@(posedge Clk) disable iff (rst) $rose(outReq) |-> !$past(outAck))
		else begin
			$display("outReq rose at %0t ns before outAck had fallen", $time);
			errCount++;
		end
	assert property (@(posedge Clk) disable iff (rst) $fell(outReq) |-> $past(outAck))
		else begin
			$display("outReq fell at %0t ns without an ack", $time);
			errCount++;
		end

	initial begin : watchdog
		repeat (numTests * cyclesPerTest) @(posedge Clk);
		$display("timeout after %0d cycles, a handshake never completed",
			numTests * cyclesPerTest);
		$display("Finished with errors");
		$finish;
	end

	initial begin
		rst = 1'b1;
		inReq = 1'b0;
		inWord = '0;
		outAck = 1'b0;
		void'($urandom(32'h2053));
		repeat (2) @(negedge Clk);
		rst = 1'b0;

		sendBlock(key1, ct1, 0);
		receiveBlock(pt1, 0);
		endTest(1, "first vector");

		sendBlock(key2, ct2, 0);
		receiveBlock(pt2, 0);
		endTest(2, "second vector");

		// outAck stays low until both blocks are in
		sendBlock(key1, ct1, 0);
		sendBlock(key2, ct2, 0);
		receiveBlock(pt1, 2);
		receiveBlock(pt2, 2);
		endTest(3, "back-to-back blocks");

		sendBlock(key2, ct2, 0);
		receiveBlock(pt2, 5);
		endTest(4, "output back-pressure");

		// reset with a word and an output both mid-handshake
		sendBlock(key2, ct2, 0);
		while (!outReq) @(negedge Clk);
		inWord = key1[127 -: 32];
		inReq = 1'b1;
		while (!inAck) @(negedge Clk);
		applyReset();
		assert (inAck === 1'b0) else begin
			$display("[FAIL] %0t ns inAck expected 0 got %b", $time, inAck);
			errCount++;
		end
		assert (outReq === 1'b0) else begin
			$display("[FAIL] %0t ns outReq expected 0 got %b", $time, outReq);
			errCount++;
		end
		sendBlock(key1, ct1, 2);
		receiveBlock(pt1, 0);
		endTest(5, "reset state and input handshake");

		// partial key then reset
		for (int i = 0; i < 3; i++) begin
			sendWord(key2[127 - 32*i -: 32], 0);
		end
		applyReset();
		sendBlock(key1, ct1, 0);
		receiveBlock(pt1, 3);
		repeat (40) begin
			@(negedge Clk);
			assert (outReq === 1'b0) else begin
				$display("[FAIL] %0t ns outReq expected 0 got %b", $time, outReq);
				errCount++;
			end
		end
		endTest(6, "reset mid-block");

		$display("tests run %0d, tests failed %0d, checks failed %0d",
			numTests, testsFailed, errCount);
		if (errCount == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule
